//--- rtl/rv_isa_pkg.sv
// rv isa package: RV64I encodings and the width types of the integer datapath
`default_nettype none

package rv_isa_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [63:0] pc_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  gpr_addr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [4:0]  alu_op_t;
  typedef logic [2:0]  mem_op_t;   // same bits as load/store funct3
  typedef logic [2:0]  br_func_t;  // same bits as branch funct3

  // major opcodes
  localparam opcode_t OPC_LUI       = 7'b0110111;
  localparam opcode_t OPC_AUIPC     = 7'b0010111;
  localparam opcode_t OPC_JAL       = 7'b1101111;
  localparam opcode_t OPC_JALR      = 7'b1100111;
  localparam opcode_t OPC_BRANCH    = 7'b1100011;
  localparam opcode_t OPC_LOAD      = 7'b0000011;
  localparam opcode_t OPC_STORE     = 7'b0100011;
  localparam opcode_t OPC_OP_IMM    = 7'b0010011;
  localparam opcode_t OPC_OP        = 7'b0110011;
  localparam opcode_t OPC_OP_IMM_32 = 7'b0011011;
  localparam opcode_t OPC_OP_32     = 7'b0111011;

  // funct3 of the integer ops
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;  // srl/sra, split by inst[30]
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  localparam alu_op_t ALU_ADD  = 5'd0;
  localparam alu_op_t ALU_SUB  = 5'd1;
  localparam alu_op_t ALU_SLL  = 5'd2;
  localparam alu_op_t ALU_SLT  = 5'd3;
  localparam alu_op_t ALU_SLTU = 5'd4;
  localparam alu_op_t ALU_XOR  = 5'd5;
  localparam alu_op_t ALU_SRL  = 5'd6;
  localparam alu_op_t ALU_SRA  = 5'd7;
  localparam alu_op_t ALU_OR   = 5'd8;
  localparam alu_op_t ALU_AND  = 5'd9;
  localparam alu_op_t ALU_LUI  = 5'd10;  // passes operand 2

  localparam mem_op_t MEM_B  = 3'b000;
  localparam mem_op_t MEM_H  = 3'b001;
  localparam mem_op_t MEM_W  = 3'b010;
  localparam mem_op_t MEM_D  = 3'b011;
  localparam mem_op_t MEM_BU = 3'b100;
  localparam mem_op_t MEM_HU = 3'b101;
  localparam mem_op_t MEM_WU = 3'b110;

  localparam br_func_t BR_BEQ  = 3'b000;
  localparam br_func_t BR_BNE  = 3'b001;
  localparam br_func_t BR_BLT  = 3'b100;
  localparam br_func_t BR_BGE  = 3'b101;
  localparam br_func_t BR_BLTU = 3'b110;
  localparam br_func_t BR_BGEU = 3'b111;

endpackage

`default_nettype wire

//--- rtl/id_bus_pkg.sv
// decode stage bus package: structs passed between decode and its neighbour stages
`default_nettype none

package id_bus_pkg;

  // fetch to decode, 96 bits
  typedef struct packed {
    rv_isa_pkg::inst_t inst;
    rv_isa_pkg::pc_t   pc;
  } fs_to_ds_t;

  // decode to execute
  typedef struct packed {
    logic                  load_sel;
    rv_isa_pkg::xlen_t     rs1_data;
    rv_isa_pkg::xlen_t     rs2_data;
    rv_isa_pkg::xlen_t     imm;
    rv_isa_pkg::pc_t       pc;
    logic                  alu_src1_sel;  // 1: pc
    logic [1:0]            alu_src2_sel;  // 0 rs2, 1 imm, 2 four
    logic                  word_cut_sel;
    rv_isa_pkg::alu_op_t   alu_op;
    rv_isa_pkg::gpr_addr_t rd;
    logic                  gpr_wen;
    logic                  mem_ren;
    logic                  mem_wen;
    rv_isa_pkg::mem_op_t   mem_op;
    logic                  invalid_inst;
  } ds_to_es_t;

  // result forwarded back from a later stage, rd of zero means nothing
  typedef struct packed {
    rv_isa_pkg::gpr_addr_t rd;
    rv_isa_pkg::xlen_t     result;
  } bypass_t;

  typedef struct packed {
    logic                  wen;
    rv_isa_pkg::gpr_addr_t waddr;
    rv_isa_pkg::xlen_t     wdata;
  } wb_to_rf_t;

  // redirect toward fetch
  typedef struct packed {
    logic            stall;
    logic            taken;
    rv_isa_pkg::pc_t target;
  } br_t;

  typedef struct packed {
    logic                 bren;
    logic                 jal_sel;
    logic                 jalr_sel;
    rv_isa_pkg::br_func_t br_func;
  } id_ctrl_t;

endpackage

`default_nettype wire

//--- rtl/id_latch.sv
// decode latch: stage valid bit, instruction/pc register and valid/allowin handshake
`timescale 1ns/1ps
`default_nettype none

module id_latch (
  input  wire                    i_clk,
  input  wire                    i_reset,
  // from fetch
  input  wire                    i_fs_valid,
  input  id_bus_pkg::fs_to_ds_t  i_fs_bus,
  // handshake
  input  wire                    i_ready_go,
  input  wire                    i_es_allowin,
  output logic                   o_allowin,
  output logic                   o_valid,
  output logic                   o_to_es_valid,
  output id_bus_pkg::fs_to_ds_t  o_ds_bus
);

  logic ds_valid;

  assign o_allowin     = !ds_valid || (i_ready_go && i_es_allowin);
  assign o_to_es_valid = ds_valid && i_ready_go;
  assign o_valid       = ds_valid;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
    end else if (o_allowin) begin
      ds_valid <= i_fs_valid;  // empties when fetch has nothing
    end
  end

  // payload only moves on an accepted transfer
  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_allowin) begin
      o_ds_bus <= i_fs_bus;
    end
  end

endmodule

`default_nettype wire

//--- rtl/id_decoder.sv
// instruction decoder: immediate, destination and execute control for RV64I
`timescale 1ns/1ps
`default_nettype none

module id_decoder (
  input  rv_isa_pkg::inst_t      i_inst,
  input  rv_isa_pkg::pc_t        i_pc,
  output rv_isa_pkg::xlen_t      o_imm,
  output rv_isa_pkg::gpr_addr_t  o_rd,
  output id_bus_pkg::id_ctrl_t   o_ctrl,
  output rv_isa_pkg::alu_op_t    o_alu_op,
  output logic                   o_alu_src1_sel,
  output logic [1:0]             o_alu_src2_sel,
  output logic                   o_word_cut_sel,
  output logic                   o_gpr_wen,
  output logic                   o_mem_ren,
  output logic                   o_mem_wen,
  output logic                   o_load_sel,
  output rv_isa_pkg::mem_op_t    o_mem_op,
  output logic                   o_invalid_inst
);

  localparam logic [1:0] SRC2_RS2  = 2'd0;
  localparam logic [1:0] SRC2_IMM  = 2'd1;
  localparam logic [1:0] SRC2_FOUR = 2'd2;

  rv_isa_pkg::opcode_t opcode;
  rv_isa_pkg::funct3_t funct3;
  rv_isa_pkg::xlen_t   imm_i, imm_s, imm_b, imm_u, imm_j;
  logic                bad;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign o_rd   = i_inst[11:7];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // inst[30] picks sub only for register ops, sra for both
  function automatic rv_isa_pkg::alu_op_t alu_sel(input rv_isa_pkg::funct3_t f3,
                                                  input logic alt, input logic reg_op);
    rv_isa_pkg::alu_op_t op;
    case (f3)
      rv_isa_pkg::F3_ADD:  op = (alt && reg_op) ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:  op = rv_isa_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:  op = rv_isa_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU: op = rv_isa_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:  op = rv_isa_pkg::ALU_XOR;
      rv_isa_pkg::F3_SR:   op = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:   op = rv_isa_pkg::ALU_OR;
      default:             op = rv_isa_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    o_imm          = '0;
    o_ctrl         = '0;
    o_alu_op       = rv_isa_pkg::ALU_ADD;
    o_alu_src1_sel = 1'b0;
    o_alu_src2_sel = SRC2_RS2;
    o_word_cut_sel = 1'b0;
    o_gpr_wen      = 1'b1;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_mem_op       = '0;
    bad            = 1'b0;
    case (opcode)
      rv_isa_pkg::OPC_LUI: begin
        o_imm          = imm_u;
        o_alu_op       = rv_isa_pkg::ALU_LUI;
        o_alu_src2_sel = SRC2_IMM;
      end
      rv_isa_pkg::OPC_AUIPC: begin
        o_imm          = imm_u;
        o_alu_src1_sel = 1'b1;
        o_alu_src2_sel = SRC2_IMM;
      end
      rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR: begin  // link = pc + 4
        o_imm           = (opcode == rv_isa_pkg::OPC_JAL) ? imm_j : imm_i;
        o_ctrl.jal_sel  = (opcode == rv_isa_pkg::OPC_JAL);
        o_ctrl.jalr_sel = (opcode == rv_isa_pkg::OPC_JALR);
        o_alu_src1_sel  = 1'b1;
        o_alu_src2_sel  = SRC2_FOUR;
        bad             = o_ctrl.jalr_sel && (funct3 != rv_isa_pkg::F3_ADD);
      end
      rv_isa_pkg::OPC_BRANCH: begin
        o_imm          = imm_b;
        o_ctrl.bren    = 1'b1;
        o_ctrl.br_func = funct3;
        o_gpr_wen      = 1'b0;
        bad            = !(funct3 inside {rv_isa_pkg::BR_BEQ, rv_isa_pkg::BR_BNE,
                                          rv_isa_pkg::BR_BLT, rv_isa_pkg::BR_BGE,
                                          rv_isa_pkg::BR_BLTU, rv_isa_pkg::BR_BGEU});
      end
      rv_isa_pkg::OPC_LOAD: begin
        o_imm          = imm_i;
        o_alu_src2_sel = SRC2_IMM;
        o_mem_ren      = 1'b1;
        o_mem_op       = funct3;
        bad            = !(funct3 inside {rv_isa_pkg::MEM_B, rv_isa_pkg::MEM_H,
                                          rv_isa_pkg::MEM_W, rv_isa_pkg::MEM_D,
                                          rv_isa_pkg::MEM_BU, rv_isa_pkg::MEM_HU,
                                          rv_isa_pkg::MEM_WU});
      end
      rv_isa_pkg::OPC_STORE: begin
        o_imm          = imm_s;
        o_alu_src2_sel = SRC2_IMM;
        o_gpr_wen      = 1'b0;
        o_mem_wen      = 1'b1;
        o_mem_op       = funct3;
        bad            = !(funct3 inside {rv_isa_pkg::MEM_B, rv_isa_pkg::MEM_H,
                                          rv_isa_pkg::MEM_W, rv_isa_pkg::MEM_D});
      end
      rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP_IMM_32: begin
        o_imm          = imm_i;
        o_alu_src2_sel = SRC2_IMM;
        o_alu_op       = alu_sel(funct3, i_inst[30], 1'b0);
        o_word_cut_sel = (opcode == rv_isa_pkg::OPC_OP_IMM_32);
      end
      rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_32: begin
        o_alu_op       = alu_sel(funct3, i_inst[30], 1'b1);
        o_word_cut_sel = (opcode == rv_isa_pkg::OPC_OP_32);
      end
      default: bad = 1'b1;
    endcase
    // word ops only have add/sub and the shifts
    if (o_word_cut_sel && !(funct3 inside {rv_isa_pkg::F3_ADD, rv_isa_pkg::F3_SLL,
                                           rv_isa_pkg::F3_SR})) begin
      bad = 1'b1;
    end
    if (i_pc[1:0] != 2'b00) bad = 1'b1;  // no compressed ext, must be word aligned
    if (o_rd == '0) o_gpr_wen = 1'b0;
    if (bad) begin
      o_ctrl    = '0;
      o_gpr_wen = 1'b0;
      o_mem_ren = 1'b0;
      o_mem_wen = 1'b0;
    end
  end

  assign o_load_sel     = o_mem_ren;
  assign o_invalid_inst = bad;

endmodule

`default_nettype wire

//--- rtl/gpr_file.sv
// general-purpose register file: two async read ports, one sync write port
`timescale 1ns/1ps
`default_nettype none

module gpr_file #(
  parameter int GPR_COUNT = 32
) (
  input  wire                    i_clk,
  input  rv_isa_pkg::gpr_addr_t  i_raddr1,
  input  rv_isa_pkg::gpr_addr_t  i_raddr2,
  output rv_isa_pkg::xlen_t      o_rdata1,
  output rv_isa_pkg::xlen_t      o_rdata2,
  input  id_bus_pkg::wb_to_rf_t  i_wb
);

  rv_isa_pkg::xlen_t regs [GPR_COUNT];
  logic              hit1, hit2, wr_ok;

  // x0 and indexes past the count read as zero
  assign hit1  = (i_raddr1 != '0) && (int'(i_raddr1) < GPR_COUNT);
  assign hit2  = (i_raddr2 != '0) && (int'(i_raddr2) < GPR_COUNT);
  assign wr_ok = i_wb.wen && (i_wb.waddr != '0) && (int'(i_wb.waddr) < GPR_COUNT);

  assign o_rdata1 = hit1 ? regs[i_raddr1] : '0;
  assign o_rdata2 = hit2 ? regs[i_raddr2] : '0;

  always_ff @(posedge i_clk) begin
    if (wr_ok) begin
      regs[i_wb.waddr] <= i_wb.wdata;
    end
  end

endmodule

`default_nettype wire

//--- rtl/id_operand.sv
// operand unit: register read, forwarding from es/ms/ws and load-use detection
`timescale 1ns/1ps
`default_nettype none

module id_operand #(
  parameter int GPR_COUNT = 32
) (
  input  wire                    i_clk,
  input  rv_isa_pkg::inst_t      i_inst,
  input  id_bus_pkg::wb_to_rf_t  i_wb,
  input  id_bus_pkg::bypass_t    i_es_bypass,
  input  id_bus_pkg::bypass_t    i_ms_bypass,
  input  id_bus_pkg::bypass_t    i_ws_bypass,
  input  wire                    i_es_load_sel,
  output rv_isa_pkg::xlen_t      o_rs1_data,
  output rv_isa_pkg::xlen_t      o_rs2_data,
  output logic                   o_load_hazard
);

  rv_isa_pkg::gpr_addr_t rs1, rs2;
  rv_isa_pkg::xlen_t     rf_rdata1, rf_rdata2;

  assign rs1 = i_inst[19:15];
  assign rs2 = i_inst[24:20];

  gpr_file #(
    .GPR_COUNT (GPR_COUNT)
  ) u_gpr_file (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .o_rdata1 (rf_rdata1),
    .i_raddr2 (rs2),
    .o_rdata2 (rf_rdata2),
    .i_wb     (i_wb)
  );

  // youngest producer wins
  function automatic rv_isa_pkg::xlen_t fwd(input rv_isa_pkg::gpr_addr_t rs,
                                            input rv_isa_pkg::xlen_t rf_data,
                                            input id_bus_pkg::bypass_t es,
                                            input id_bus_pkg::bypass_t ms,
                                            input id_bus_pkg::bypass_t ws);
    if (es.rd != '0 && es.rd == rs) return es.result;
    if (ms.rd != '0 && ms.rd == rs) return ms.result;
    if (ws.rd != '0 && ws.rd == rs) return ws.result;
    return rf_data;
  endfunction

  assign o_rs1_data = fwd(rs1, rf_rdata1, i_es_bypass, i_ms_bypass, i_ws_bypass);
  assign o_rs2_data = fwd(rs2, rf_rdata2, i_es_bypass, i_ms_bypass, i_ws_bypass);

  // load data only exists after mem, so wait one cycle for it
  assign o_load_hazard = i_es_load_sel && (i_es_bypass.rd != '0) &&
                         ((i_es_bypass.rd == rs1) || (i_es_bypass.rd == rs2));

endmodule

`default_nettype wire

//--- rtl/id_branch.sv
// branch unit: condition evaluation, jump target and redirect toward fetch
`timescale 1ns/1ps
`default_nettype none

module id_branch (
  input  wire                   i_valid,
  input  id_bus_pkg::id_ctrl_t  i_ctrl,
  input  rv_isa_pkg::pc_t       i_pc,
  input  rv_isa_pkg::xlen_t     i_imm,
  input  rv_isa_pkg::xlen_t     i_rs1_data,
  input  rv_isa_pkg::xlen_t     i_rs2_data,
  input  wire                   i_load_hazard,
  output id_bus_pkg::br_t       o_br
);

  logic            cond;
  logic            eq, lt, ltu;
  rv_isa_pkg::pc_t jalr_sum;

  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_ctrl.br_func)
      rv_isa_pkg::BR_BEQ:  cond = eq;
      rv_isa_pkg::BR_BNE:  cond = !eq;
      rv_isa_pkg::BR_BLT:  cond = lt;
      rv_isa_pkg::BR_BGE:  cond = !lt;
      rv_isa_pkg::BR_BLTU: cond = ltu;
      rv_isa_pkg::BR_BGEU: cond = !ltu;
      default:             cond = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1_data + i_imm;

  assign o_br.taken  = i_valid && (i_ctrl.jal_sel || i_ctrl.jalr_sel ||
                                   (i_ctrl.bren && cond));
  assign o_br.target = i_ctrl.jalr_sel ? {jalr_sum[63:1], 1'b0} : i_pc + i_imm;
  // operands not final yet, fetch must hold off
  assign o_br.stall  = o_br.taken && i_load_hazard;

endmodule

`default_nettype wire

//--- rtl/id_stage.sv
// decode stage top: latch, decoder, operand unit and branch unit
`timescale 1ns/1ps
`default_nettype none

module id_stage #(
  parameter int GPR_COUNT = 32
) (
  input  wire                    i_clk,
  input  wire                    i_reset,
  // from fetch
  input  wire                    i_fs_to_ds_valid,
  input  id_bus_pkg::fs_to_ds_t  i_fs_to_ds_bus,
  output logic                   o_ds_allowin,
  // to execute
  input  wire                    i_es_allowin,
  output logic                   o_ds_to_es_valid,
  output id_bus_pkg::ds_to_es_t  o_ds_to_es_bus,
  // to fetch
  output id_bus_pkg::br_t        o_br_bus,
  // write back and bypass
  input  id_bus_pkg::wb_to_rf_t  i_ws_to_rf,
  input  wire                    i_es_load_sel,
  input  id_bus_pkg::bypass_t    i_es_bypass,
  input  id_bus_pkg::bypass_t    i_ms_bypass,
  input  id_bus_pkg::bypass_t    i_ws_bypass
);

  id_bus_pkg::fs_to_ds_t ds_bus;
  id_bus_pkg::id_ctrl_t  ctrl;
  rv_isa_pkg::xlen_t     imm, rs1_data, rs2_data;
  logic                  ds_valid;
  logic                  load_hazard;

  id_latch u_latch (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_fs_valid    (i_fs_to_ds_valid),
    .i_fs_bus      (i_fs_to_ds_bus),
    .i_ready_go    (!load_hazard),
    .i_es_allowin  (i_es_allowin),
    .o_allowin     (o_ds_allowin),
    .o_valid       (ds_valid),
    .o_to_es_valid (o_ds_to_es_valid),
    .o_ds_bus      (ds_bus)
  );

  id_decoder u_decoder (
    .i_inst         (ds_bus.inst),
    .i_pc           (ds_bus.pc),
    .o_imm          (imm),
    .o_rd           (o_ds_to_es_bus.rd),
    .o_ctrl         (ctrl),
    .o_alu_op       (o_ds_to_es_bus.alu_op),
    .o_alu_src1_sel (o_ds_to_es_bus.alu_src1_sel),
    .o_alu_src2_sel (o_ds_to_es_bus.alu_src2_sel),
    .o_word_cut_sel (o_ds_to_es_bus.word_cut_sel),
    .o_gpr_wen      (o_ds_to_es_bus.gpr_wen),
    .o_mem_ren      (o_ds_to_es_bus.mem_ren),
    .o_mem_wen      (o_ds_to_es_bus.mem_wen),
    .o_load_sel     (o_ds_to_es_bus.load_sel),
    .o_mem_op       (o_ds_to_es_bus.mem_op),
    .o_invalid_inst (o_ds_to_es_bus.invalid_inst)
  );

  id_operand #(
    .GPR_COUNT (GPR_COUNT)
  ) u_operand (
    .i_clk         (i_clk),
    .i_inst        (ds_bus.inst),
    .i_wb          (i_ws_to_rf),
    .i_es_bypass   (i_es_bypass),
    .i_ms_bypass   (i_ms_bypass),
    .i_ws_bypass   (i_ws_bypass),
    .i_es_load_sel (i_es_load_sel),
    .o_rs1_data    (rs1_data),
    .o_rs2_data    (rs2_data),
    .o_load_hazard (load_hazard)
  );

  id_branch u_branch (
    .i_valid       (ds_valid),
    .i_ctrl        (ctrl),
    .i_pc          (ds_bus.pc),
    .i_imm         (imm),
    .i_rs1_data    (rs1_data),
    .i_rs2_data    (rs2_data),
    .i_load_hazard (load_hazard),
    .o_br          (o_br_bus)
  );

  // remaining execute fields
  assign o_ds_to_es_bus.rs1_data = rs1_data;
  assign o_ds_to_es_bus.rs2_data = rs2_data;
  assign o_ds_to_es_bus.imm      = imm;
  assign o_ds_to_es_bus.pc       = ds_bus.pc;

endmodule

`default_nettype wire

//--- tb/id_stage_assert.sv
// decode stage checker: handshake, reset and redirect properties bound to the stage
`timescale 1ns/1ps
`default_nettype none

module id_stage_assert (
  input  wire                    i_clk,
  input  wire                    i_reset,
  input  wire                    i_fs_valid,
  input  wire                    i_ds_allowin,
  input  wire                    i_es_allowin,
  input  wire                    i_ds_to_es_valid,
  input  id_bus_pkg::ds_to_es_t  i_ds_to_es_bus,
  input  id_bus_pkg::br_t        i_br_bus,
  input  id_bus_pkg::wb_to_rf_t  i_ws_to_rf,
  input  id_bus_pkg::bypass_t    i_es_bypass,
  input  id_bus_pkg::bypass_t    i_ms_bypass,
  input  id_bus_pkg::bypass_t    i_ws_bypass
);

  logic occupied;  // an instruction was taken from fetch and not yet passed on

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      occupied <= 1'b0;
    end else if (i_ds_allowin) begin
      occupied <= i_fs_valid;
    end
  end

  a_valid_after_accept: assert property (@(posedge i_clk) disable iff (i_reset)
    i_ds_to_es_valid |-> occupied)
    else $error("output valid without an accepted instruction");

  a_idle_after_reset: assert property (@(posedge i_clk)
    i_reset |=> (!i_ds_to_es_valid && !i_br_bus.taken))
    else $error("stage not idle after reset");

  // a stalled redirect also holds the stage
  a_stall_holds_stage: assert property (@(posedge i_clk) disable iff (i_reset)
    i_br_bus.stall |-> (i_br_bus.taken && !i_ds_to_es_valid && !i_ds_allowin))
    else $error("branch stall raised without a taken redirect and a held stage");

  // held instruction with quiet bypass and no register write
  a_bus_held: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_ds_to_es_valid && !i_es_allowin && !i_ws_to_rf.wen) ##1
    ($stable(i_es_bypass) && $stable(i_ms_bypass) && $stable(i_ws_bypass))
    |-> $stable(i_ds_to_es_bus))
    else $error("output bus changed under back-pressure");

endmodule

bind id_stage id_stage_assert u_assert (
  .i_clk            (i_clk),
  .i_reset          (i_reset),
  .i_fs_valid       (i_fs_to_ds_valid),
  .i_ds_allowin     (o_ds_allowin),
  .i_es_allowin     (i_es_allowin),
  .i_ds_to_es_valid (o_ds_to_es_valid),
  .i_ds_to_es_bus   (o_ds_to_es_bus),
  .i_br_bus         (o_br_bus),
  .i_ws_to_rf       (i_ws_to_rf),
  .i_es_bypass      (i_es_bypass),
  .i_ms_bypass      (i_ms_bypass),
  .i_ws_bypass      (i_ws_bypass)
);

`default_nettype wire

//--- tb/id_stage_vectors.svh
// decode stage vectors: stimulus and expected decode, operand and redirect results
`ifndef ID_STAGE_VECTORS_SVH
`define ID_STAGE_VECTORS_SVH

  // where an operand is expected to come from
  localparam logic [1:0] SRC_RF = 2'd0;
  localparam logic [1:0] SRC_ES = 2'd1;
  localparam logic [1:0] SRC_MS = 2'd2;
  localparam logic [1:0] SRC_WS = 2'd3;

  typedef struct packed {
    logic [31:0] inst;
    logic [63:0] pc;
    logic [4:0]  es_rd;
    logic [4:0]  ms_rd;
    logic [4:0]  ws_rd;
    logic        load_sel;
    logic        es_allowin;
    logic [63:0] imm;
    logic [4:0]  rd;
    logic [3:0]  en;    // gpr_wen mem_ren mem_wen invalid
    logic [3:0]  flow;  // hazard taken stall jalr_target
    logic [1:0]  src1;
    logic [1:0]  src2;
  } vec_t;

  localparam int VEC_COUNT = 16;

  // columns: inst, pc, es/ms/ws rd, es_load_sel, es_allowin,
  //          imm, rd, enables, flow, rs1 source, rs2 source
  localparam vec_t VECTORS [VEC_COUNT] = '{
    '{32'hffb08193, 64'h8000_0000, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1,    // addi x3, x1, -5
      64'hffff_ffff_ffff_fffb, 5'd3, 4'b1000, 4'b0000, SRC_RF, SRC_RF},
    '{32'h800012b7, 64'h8000_0004, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1,    // lui x5, 0x80001
      64'hffff_ffff_8000_1000, 5'd5, 4'b1000, 4'b0000, SRC_RF, SRC_RF},
    '{32'h01013303, 64'h8000_0008, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1,    // ld x6, 16(x2)
      64'h10, 5'd6, 4'b1100, 4'b0000, SRC_RF, SRC_RF},
    '{32'hfe723c23, 64'h8000_000c, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1,    // sd x7, -8(x4)
      64'hffff_ffff_ffff_fff8, 5'd24, 4'b0010, 4'b0000, SRC_RF, SRC_RF},
    '{32'h000002ff, 64'h8000_0010, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1,    // unknown opcode
      64'h0, 5'd5, 4'b0001, 4'b0000, SRC_RF, SRC_RF},
    '{32'h00a48433, 64'h8000_0014, 5'd9, 5'd9, 5'd9, 1'b0, 1'b1,    // add x8, x9, x10
      64'h0, 5'd8, 4'b1000, 4'b0000, SRC_ES, SRC_RF},
    '{32'h00a48433, 64'h8000_0018, 5'd12, 5'd9, 5'd9, 1'b0, 1'b1,   // add, ms and ws hit
      64'h0, 5'd8, 4'b1000, 4'b0000, SRC_MS, SRC_RF},
    '{32'h00a48433, 64'h8000_001c, 5'd10, 5'd0, 5'd0, 1'b1, 1'b1,   // add after load to x10
      64'h0, 5'd8, 4'b1000, 4'b1000, SRC_RF, SRC_ES},
    '{32'h00b58863, 64'h8000_1000, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1,    // beq x11, x11, +16
      64'h10, 5'd16, 4'b0000, 4'b0100, SRC_RF, SRC_RF},
    '{32'h00b59863, 64'h8000_1004, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1,    // bne x11, x11, +16
      64'h10, 5'd16, 4'b0000, 4'b0000, SRC_RF, SRC_RF},
    '{32'hfed640e3, 64'h8000_2000, 5'd12, 5'd13, 5'd0, 1'b0, 1'b1,  // blt x12, x13, -32
      64'hffff_ffff_ffff_ffe0, 5'd1, 4'b0000, 4'b0100, SRC_ES, SRC_MS},
    '{32'hfed660e3, 64'h8000_2004, 5'd12, 5'd13, 5'd0, 1'b0, 1'b1,  // bltu x12, x13, -32
      64'hffff_ffff_ffff_ffe0, 5'd1, 4'b0000, 4'b0000, SRC_ES, SRC_MS},
    '{32'hfed640e3, 64'h8000_2008, 5'd12, 5'd13, 5'd0, 1'b1, 1'b1,  // blt behind a load
      64'hffff_ffff_ffff_ffe0, 5'd1, 4'b0000, 4'b1110, SRC_ES, SRC_MS},
    '{32'h001000ef, 64'h8000_3000, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1,    // jal x1, +2048
      64'h800, 5'd1, 4'b1000, 4'b0100, SRC_RF, SRC_RF},
    '{32'h005700e7, 64'h8000_3004, 5'd0, 5'd0, 5'd14, 1'b0, 1'b1,   // jalr x1, 5(x14)
      64'h5, 5'd1, 4'b1000, 4'b0101, SRC_WS, SRC_RF},
    '{32'hffb08193, 64'h8000_4000, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0,    // addi, execute busy
      64'hffff_ffff_ffff_fffb, 5'd3, 4'b1000, 4'b0000, SRC_RF, SRC_RF}
  };

`endif

//--- tb/id_stage_tb.sv
// decode stage testbench: table-driven decode, forwarding, stall and redirect checks
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb;

  localparam int          TIMEOUT_CYCLES = 20;
  localparam logic [63:0] ES_RESULT      = 64'hffff_ffff_ffff_fff0;  // negative on purpose
  localparam logic [63:0] MS_RESULT      = 64'h0000_0000_0000_0010;
  localparam logic [63:0] WS_RESULT      = 64'h0000_0000_8000_4000;

  `include "id_stage_vectors.svh"

  logic                  clk;
  logic                  reset;
  logic                  fs_valid;
  id_bus_pkg::fs_to_ds_t fs_bus;
  logic                  ds_allowin;
  logic                  es_allowin;
  logic                  ds_to_es_valid;
  id_bus_pkg::ds_to_es_t ds_to_es_bus;
  id_bus_pkg::br_t       br_bus;
  id_bus_pkg::wb_to_rf_t ws_to_rf;
  logic                  es_load_sel;
  id_bus_pkg::bypass_t   es_bypass;
  id_bus_pkg::bypass_t   ms_bypass;
  id_bus_pkg::bypass_t   ws_bypass;

  logic [63:0] model [32];  // register contents as written by the preload
  integer      seed;

  id_stage #(
    .GPR_COUNT (32)
  ) i_dut (
    .i_clk            (clk),
    .i_reset          (reset),
    .i_fs_to_ds_valid (fs_valid),
    .i_fs_to_ds_bus   (fs_bus),
    .o_ds_allowin     (ds_allowin),
    .i_es_allowin     (es_allowin),
    .o_ds_to_es_valid (ds_to_es_valid),
    .o_ds_to_es_bus   (ds_to_es_bus),
    .o_br_bus         (br_bus),
    .i_ws_to_rf       (ws_to_rf),
    .i_es_load_sel    (es_load_sel),
    .i_es_bypass      (es_bypass),
    .i_ms_bypass      (ms_bypass),
    .i_ws_bypass      (ws_bypass)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "decode stage check failed");
    end
  endtask

  task automatic wait_for_allowin();
    int cycles;
    cycles = 0;
    while (!ds_allowin) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout: decode stage never became ready to accept an instruction");
        $display("=== FAIL ===");
        $fatal(1, "allowin timeout");
      end
    end
  endtask

  task automatic wait_for_valid();
    int cycles;
    cycles = 0;
    while (!ds_to_es_valid) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout: decode stage never passed its instruction to execute");
        $display("=== FAIL ===");
        $fatal(1, "output valid timeout");
      end
    end
  endtask

  // one write per cycle through the write-back port
  task automatic preload_registers();
    logic [63:0] value;
    model[0] = '0;
    for (int r = 1; r < 32; r++) begin
      value          = {$random(seed), $random(seed)};
      model[r]       = value;
      ws_to_rf.wen   = 1'b1;
      ws_to_rf.waddr = 5'(r);
      ws_to_rf.wdata = value;
      @(posedge clk);
      #1;
    end
    ws_to_rf = '0;
  endtask

  function automatic logic [63:0] source_value(input logic [1:0] src, input logic [4:0] idx);
    case (src)
      SRC_ES:  return ES_RESULT;
      SRC_MS:  return MS_RESULT;
      SRC_WS:  return WS_RESULT;
      default: return model[idx];
    endcase
  endfunction

  task automatic apply_row(input int idx);
    vec_t                  v;
    logic [63:0]           exp_rs1;
    logic [63:0]           exp_rs2;
    logic [63:0]           exp_target;
    id_bus_pkg::ds_to_es_t held;
    v          = VECTORS[idx];
    exp_rs1    = source_value(v.src1, v.inst[19:15]);
    exp_rs2    = source_value(v.src2, v.inst[24:20]);
    exp_target = v.flow[0] ? ((exp_rs1 + v.imm) & ~64'd1) : (v.pc + v.imm);
    wait_for_allowin();
    fs_valid    = 1'b1;
    fs_bus.inst = v.inst;
    fs_bus.pc   = v.pc;
    es_bypass   = '{rd: v.es_rd, result: ES_RESULT};
    ms_bypass   = '{rd: v.ms_rd, result: MS_RESULT};
    ws_bypass   = '{rd: v.ws_rd, result: WS_RESULT};
    es_load_sel = v.load_sel;
    es_allowin  = v.es_allowin;
    @(posedge clk);
    #1;
    fs_valid = 1'b0;
    #4;
    check_field("o_ds_to_es_valid", 64'(ds_to_es_valid), 64'(!v.flow[3]));
    check_field("o_ds_allowin", 64'(ds_allowin), 64'(!v.flow[3] && v.es_allowin));
    check_field("imm", ds_to_es_bus.imm, v.imm);
    check_field("pc", ds_to_es_bus.pc, v.pc);
    check_field("rd", 64'(ds_to_es_bus.rd), 64'(v.rd));
    check_field("gpr_wen", 64'(ds_to_es_bus.gpr_wen), 64'(v.en[3]));
    check_field("mem_ren", 64'(ds_to_es_bus.mem_ren), 64'(v.en[2]));
    check_field("mem_wen", 64'(ds_to_es_bus.mem_wen), 64'(v.en[1]));
    check_field("invalid_inst", 64'(ds_to_es_bus.invalid_inst), 64'(v.en[0]));
    check_field("rs1_data", ds_to_es_bus.rs1_data, exp_rs1);
    check_field("rs2_data", ds_to_es_bus.rs2_data, exp_rs2);
    check_field("br taken", 64'(br_bus.taken), 64'(v.flow[2]));
    check_field("br stall", 64'(br_bus.stall), 64'(v.flow[1]));
    if (v.flow[2]) begin
      check_field("br target", br_bus.target, exp_target);
    end
    if (v.flow[3]) begin
      // load-use: stays blocked until the load select drops
      @(posedge clk);
      #1;
      check_field("o_ds_to_es_valid", 64'(ds_to_es_valid), 64'd0);
      check_field("o_ds_allowin", 64'(ds_allowin), 64'd0);
      es_load_sel = 1'b0;
      #1;
      check_field("o_ds_to_es_valid", 64'(ds_to_es_valid), 64'd1);
      check_field("o_ds_allowin", 64'(ds_allowin), 64'd1);
    end
    if (!v.es_allowin) begin
      held        = ds_to_es_bus;
      // fetch offers another instruction that must not get in
      fs_valid    = 1'b1;
      fs_bus.inst = ~v.inst;
      fs_bus.pc   = ~v.pc;
      repeat (2) begin
        @(posedge clk);
        #1;
        check_field("o_ds_allowin", 64'(ds_allowin), 64'd0);
      end
      check_field("held rs1_data", ds_to_es_bus.rs1_data, held.rs1_data);
      check_field("held imm", ds_to_es_bus.imm, held.imm);
      check_field("held pc", ds_to_es_bus.pc, held.pc);
      fs_valid   = 1'b0;
      es_allowin = 1'b1;
    end
    wait_for_valid();
    @(posedge clk);
    #1;
    check_field("o_ds_to_es_valid", 64'(ds_to_es_valid), 64'd0);
    check_field("o_ds_allowin", 64'(ds_allowin), 64'd1);
    es_bypass = '0;
    ms_bypass = '0;
    ws_bypass = '0;
  endtask

  initial begin
    reset       = 1'b1;
    fs_valid    = 1'b0;
    fs_bus      = '0;
    es_allowin  = 1'b1;
    ws_to_rf    = '0;
    es_load_sel = 1'b0;
    es_bypass   = '0;
    ms_bypass   = '0;
    ws_bypass   = '0;
    seed        = 32'hcf31_f67c;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    preload_registers();
    for (int i = 0; i < VEC_COUNT; i++) begin
      apply_row(i);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- id_stage.f
+incdir+tb
rtl/rv_isa_pkg.sv
rtl/id_bus_pkg.sv
rtl/id_latch.sv
rtl/id_decoder.sv
rtl/gpr_file.sv
rtl/id_operand.sv
rtl/id_branch.sv
rtl/id_stage.sv
tb/id_stage_assert.sv
tb/id_stage_tb.sv
